/* qla_defines.svh */
/* motor-axis core constants
   address map, register offsets, field widths and safety limits */
`ifndef QLA_DEFINES_SVH
`define QLA_DEFINES_SVH

// ------------------------------------------------------------
// widths
`define QLA_NUM_AXES    4           // axes 1..4
`define REG_AW          16          // host address bus
`define REG_DW          32          // host data bus
`define CUR_W           16          // dac / adc word
`define ENC_W           24          // quadrature counter

// ------------------------------------------------------------
// address map
`define ADDR_SPACE_MAIN 4'h0        // addr[15:12], board registers
`define CHAN_BOARD      4'h0        // addr[7:4], channel 0 is the board

// offsets within a channel, addr[3:0]
`define OFF_STATUS      4'h0        // channel 0 only
`define OFF_ADC_DATA    4'h0        // axes
`define OFF_DAC_CTRL    4'h1
`define OFF_ENC_LOAD    4'h4
`define OFF_ENC_DATA    4'h5

// ------------------------------------------------------------
// current and safety
`define CUR_MID         16'h8000    // zero current, offset binary
`define SAFETY_MARGIN   16'h0100    // slack on top of 2x command
`define SAFETY_CYCLES   8           // consecutive over-limit cycles to trip
`define STATUS_PWR_BIT  19          // power enable in status word

`endif

/* qla_pkg.sv */
/* shared types for the motor-axis core
   register bus words, per-axis vectors and the safety FSM states */
`include "qla_defines.svh"

package qla_pkg;

    // plain vectors
    typedef logic [`REG_AW-1:0]       reg_addr_t;
    typedef logic [`REG_DW-1:0]       reg_data_t;
    typedef logic [`CUR_W-1:0]        cur_t;         // offset binary
    typedef logic [`ENC_W-1:0]        enc_count_t;
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;   // bit 0 is axis 1
    typedef logic [3:0]               board_id_t;
    typedef logic [3:0]               chan_t;        // addr[7:4]
    typedef logic [3:0]               off_t;         // addr[3:0]

    // one host write, sampled on the clock edge
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        reg_data_t wdata;
    } reg_wr_t;

    // four currents, axis 4 in the top bits
    typedef struct packed {
        cur_t ax4;
        cur_t ax3;
        cur_t ax2;
        cur_t ax1;
    } cur_vec_t;

    // raw encoder pins
    typedef struct packed {
        axis_mask_t a;
        axis_mask_t b;
    } enc_pins_t;

    typedef enum logic [1:0] {
        SAFE_OK,
        SAFE_COUNT,
        SAFE_TRIP
    } safe_state_t;

    // write hit on main space, given channel and offset
    function automatic logic reg_hit(reg_wr_t wr, chan_t chan, off_t off);
        return wr.wen && (wr.waddr[15:12] == `ADDR_SPACE_MAIN) &&
               (wr.waddr[7:4] == chan) && (wr.waddr[3:0] == off);
    endfunction

endpackage

/* dac_cmd_regs.sv */
/* current command registers, one per axis
   written by the host, read back through the top level mux */
`include "qla_defines.svh"

module dac_cmd_regs import qla_pkg::*; (
    input  logic     sysclk,
    input  logic     rst,
    input  reg_wr_t  reg_wr,      // host write
    output cur_vec_t cur_cmd      // dac setpoints, axis 4..1
);

    // ------------------------------------------------------------
    // command storage, index is the channel number
    cur_t [`QLA_NUM_AXES:1] cmd_q;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                cmd_q[i] <= `CUR_MID;          // zero current
            end
        end else begin
            // each axis decodes its own channel
            for (int i = 1; i <= `QLA_NUM_AXES; i++) begin
                if (reg_hit(reg_wr, chan_t'(i), `OFF_DAC_CTRL)) begin
                    cmd_q[i] <= reg_wr.wdata[`CUR_W-1:0];   // low half only
                end
            end
        end
    end

    // packed array lines up with the struct, ax4 on top
    assign cur_cmd = cmd_q;

endmodule

/* enc_quad.sv */
/* quadrature decoder for one axis
   two-flop pin sync, 4x decode, host preload of the 24-bit count */
`include "qla_defines.svh"

module enc_quad import qla_pkg::*; #(
    parameter int AXIS = 1             // channel this counter answers to
) (
    input  logic       sysclk,
    input  logic       rst,
    input  reg_wr_t    reg_wr,
    input  logic       a,              // raw pin, async
    input  logic       b,              // raw pin, async
    output enc_count_t count,
    output enc_count_t preload         // last value written to OFF_ENC_LOAD
);

    // ------------------------------------------------------------
    // pin synchronizer
    logic [1:0] sync_a;                // [1] is the settled stage
    logic [1:0] sync_b;
    logic       cur_a;
    logic       cur_b;
    logic       prev_a;                // settled pins one cycle back
    logic       prev_b;
    logic       step;
    logic       up;
    logic       load;

    always_ff @(posedge sysclk) begin
        sync_a <= {sync_a[0], a};
        sync_b <= {sync_b[0], b};
    end

    assign cur_a = sync_a[1];
    assign cur_b = sync_b[1];

    // ------------------------------------------------------------
    // decode
    // exactly one line moved, a double move drops out here
    assign step = (cur_a ^ prev_a) ^ (cur_b ^ prev_b);
    // a leading b gives 00 10 11 01, all with a != old b
    assign up   = cur_a ^ prev_b;

    assign load = reg_hit(reg_wr, chan_t'(AXIS), `OFF_ENC_LOAD);

    always_ff @(posedge sysclk) begin
        // follows the pins through reset, no false step after it
        prev_a <= cur_a;
        prev_b <= cur_b;
        if (rst) begin
            count   <= '0;
            preload <= '0;
        end else if (load) begin           // preload beats a step
            preload <= reg_wr.wdata[`ENC_W-1:0];
            count   <= reg_wr.wdata[`ENC_W-1:0];
        end else if (step) begin
            count   <= up ? count + 1'b1 : count - 1'b1;   // wraps
        end
    end

endmodule

/* safety_check.sv */
/* runaway-current check for one axis
   latches an amplifier disable when feedback outruns the command */
`include "qla_defines.svh"

module safety_check import qla_pkg::*; (
    input  logic sysclk,
    input  logic rst,
    input  cur_t cur_fb,              // adc feedback
    input  cur_t cur_cmd,             // dac command
    input  logic clear,               // from the status write
    output logic amp_disable          // latched trip
);

    localparam int CNT_W = $clog2(`SAFETY_CYCLES + 1);

    // ------------------------------------------------------------
    // deviations from zero current
    cur_t              fb_dev;
    cur_t              cmd_dev;
    logic [`CUR_W+1:0] limit;         // 2x command plus margin, no overflow
    logic              over;

    assign fb_dev  = (cur_fb  >= `CUR_MID) ? cur_fb  - `CUR_MID : `CUR_MID - cur_fb;
    assign cmd_dev = (cur_cmd >= `CUR_MID) ? cur_cmd - `CUR_MID : `CUR_MID - cur_cmd;

    assign limit = {1'b0, cmd_dev, 1'b0} + (`CUR_W+2)'(`SAFETY_MARGIN);
    assign over  = {2'b00, fb_dev} > limit;     // equal is still fine

    // ------------------------------------------------------------
    // FSM, counts consecutive over cycles
    safe_state_t      state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= SAFE_OK;
            cnt   <= '0;
        end else begin
            unique case (state)
                SAFE_OK: begin
                    if (over) begin
                        state <= SAFE_COUNT;
                        cnt   <= CNT_W'(1);    // first over cycle seen
                    end
                end
                SAFE_COUNT: begin
                    if (!over) begin
                        state <= SAFE_OK;      // run broken
                    end else if (cnt == CNT_W'(`SAFETY_CYCLES - 1)) begin
                        state <= SAFE_TRIP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SAFE_TRIP: begin
                    if (clear) begin
                        state <= SAFE_OK;      // host acknowledged
                    end
                end
                default: state <= SAFE_OK;
            endcase
        end
    end

    assign amp_disable = (state == SAFE_TRIP);

endmodule

/* board_regs.sv */
/* channel-0 board register
   power enable, amplifier request mask and the packed status word */
`include "qla_defines.svh"

module board_regs import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  reg_wr_t    reg_wr,
    input  board_id_t  board_id,        // rotary switch
    input  axis_mask_t safety_disable,  // latched trips, bit 0 is axis 1
    output reg_data_t  status,
    output axis_mask_t amp_enable,
    output logic       pwr_enable,
    output logic       safety_clear     // one cycle after a status write
);

    // ------------------------------------------------------------
    // host write
    axis_mask_t amp_req;                // requested amps
    logic       status_wr;

    assign status_wr = reg_hit(reg_wr, `CHAN_BOARD, `OFF_STATUS);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_req      <= '0;
            pwr_enable   <= 1'b0;
            safety_clear <= 1'b0;
        end else begin
            if (status_wr) begin
                amp_req    <= reg_wr.wdata[`QLA_NUM_AXES-1:0];
                pwr_enable <= reg_wr.wdata[`STATUS_PWR_BIT];
            end
            // any status write also acks the safety latches
            safety_clear <= status_wr;
        end
    end

    // ------------------------------------------------------------
    // amplifier enables
    // a trip drops its amp in the same cycle
    assign amp_enable = amp_req & {`QLA_NUM_AXES{pwr_enable}} & ~safety_disable;

    // ------------------------------------------------------------
    // status word
    always_comb begin
        status                  = '0;
        status[3:0]             = amp_enable;      // actual
        status[7:4]             = amp_req;         // requested
        status[11:8]            = safety_disable;
        status[`STATUS_PWR_BIT] = pwr_enable;
        status[27:24]           = board_id;
    end

endmodule

/* qla_top.sv */
/* four-axis motor core top level
   dac commands, encoders, safety checks, board register and read mux */
`include "qla_defines.svh"

module qla_top import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  reg_wr_t    reg_wr,          // host write strobe, addr, data
    input  reg_addr_t  reg_raddr,       // host read address
    input  cur_vec_t   cur_fb,          // adc results
    input  enc_pins_t  enc,             // quadrature pins
    input  board_id_t  board_id,
    output reg_data_t  reg_rdata,       // combinational read data
    output cur_vec_t   cur_cmd,         // dac setpoints
    output axis_mask_t amp_enable,
    output logic       pwr_enable,
    output axis_mask_t safety_disable
);

    // ------------------------------------------------------------
    // per-axis views, index is the channel
    cur_t       [`QLA_NUM_AXES:1] fb_arr;
    cur_t       [`QLA_NUM_AXES:1] cmd_arr;
    enc_count_t [`QLA_NUM_AXES:1] count_arr;
    enc_count_t [`QLA_NUM_AXES:1] preload_arr;
    reg_data_t                    status;
    logic                         safety_clear;

    assign fb_arr  = cur_fb;
    assign cmd_arr = cur_cmd;

    dac_cmd_regs u_dac (
        .sysclk (sysclk),
        .rst    (rst),
        .reg_wr (reg_wr),
        .cur_cmd(cur_cmd)
    );

    for (genvar i = 1; i <= `QLA_NUM_AXES; i++) begin : g_axis
        enc_quad #(.AXIS(i)) u_enc (
            .sysclk (sysclk),
            .rst    (rst),
            .reg_wr (reg_wr),
            .a      (enc.a[i-1]),
            .b      (enc.b[i-1]),
            .count  (count_arr[i]),
            .preload(preload_arr[i])
        );

        safety_check u_safe (
            .sysclk     (sysclk),
            .rst        (rst),
            .cur_fb     (fb_arr[i]),
            .cur_cmd    (cmd_arr[i]),
            .clear      (safety_clear),
            .amp_disable(safety_disable[i-1])
        );
    end

    board_regs u_chan0 (
        .sysclk        (sysclk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .board_id      (board_id),
        .safety_disable(safety_disable),
        .status        (status),
        .amp_enable    (amp_enable),
        .pwr_enable    (pwr_enable),
        .safety_clear  (safety_clear)
    );

    // ------------------------------------------------------------
    // read mux: space, then channel, then offset
    chan_t rd_chan;
    off_t  rd_off;

    assign rd_chan = reg_raddr[7:4];
    assign rd_off  = reg_raddr[3:0];

    always_comb begin
        reg_rdata = '0;                         // unmapped reads 0
        if (reg_raddr[15:12] == `ADDR_SPACE_MAIN) begin
            if (rd_chan == `CHAN_BOARD) begin
                if (rd_off == `OFF_STATUS) reg_rdata = status;
            end else if (rd_chan <= `QLA_NUM_AXES) begin
                case (rd_off)
                    `OFF_ADC_DATA: reg_rdata = reg_data_t'(fb_arr[rd_chan]);
                    `OFF_DAC_CTRL: reg_rdata = reg_data_t'(cmd_arr[rd_chan]);
                    `OFF_ENC_LOAD: reg_rdata = reg_data_t'(preload_arr[rd_chan]);
                    `OFF_ENC_DATA: reg_rdata = reg_data_t'(count_arr[rd_chan]);
                    default:       reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

/* qla_sva.sv */
/* amplifier enable assertions for the motor-axis core
   bound into qla_top */
module qla_sva import qla_pkg::*; (
    input logic       sysclk,
    input logic       rst,
    input axis_mask_t amp_enable,
    input logic       pwr_enable,
    input axis_mask_t safety_disable
);

    // ------------------------------------------------------------
    // a tripped axis never drives its amp
    property p_trip_blocks_amp;
        @(posedge sysclk) disable iff (rst)
            (amp_enable & safety_disable) == '0;
    endproperty

    // amps only with board power
    property p_amp_needs_pwr;
        @(posedge sysclk) disable iff (rst)
            (amp_enable != '0) |-> pwr_enable;
    endproperty

    // everything off one cycle into reset
    property p_reset_clears;
        @(posedge sysclk)
            rst |=> (amp_enable == '0) && (safety_disable == '0);
    endproperty

    a_trip_blocks_amp: assert property (p_trip_blocks_amp)
        else $error("amp enabled on an axis with a latched safety disable");
    a_amp_needs_pwr: assert property (p_amp_needs_pwr)
        else $error("amp enabled while board power is off");
    a_reset_clears: assert property (p_reset_clears)
        else $error("amp enable or safety disable still set after reset");

endmodule

bind qla_top qla_sva u_sva (
    .sysclk        (sysclk),
    .rst           (rst),
    .amp_enable    (amp_enable),
    .pwr_enable    (pwr_enable),
    .safety_disable(safety_disable)
);

/* tb_qla.sv */
/* testbench for the four-axis motor core
   table of host writes, feedback and encoder pins applied in a loop */
`include "qla_defines.svh"

module tb_qla import qla_pkg::*; ();

    localparam int        CLK_PERIOD  = 40;
    localparam int        RST_CYCLES  = 16;
    localparam int        DRIVE_DLY   = 2;              // after the rising edge
    localparam board_id_t BOARD_ID    = 4'hA;
    localparam reg_addr_t STATUS_ADDR = {`ADDR_SPACE_MAIN, 4'h0, `CHAN_BOARD, `OFF_STATUS};

    // one table row, inputs then expected values
    typedef struct packed {
        logic       wen;
        reg_addr_t  waddr;
        reg_data_t  wdata;
        cur_vec_t   fb;
        enc_pins_t  pins;
        int         hold;                               // cycles before the check
        reg_addr_t  raddr;
        reg_data_t  exp_rdata;
        axis_mask_t exp_amp;
        axis_mask_t exp_sdis;
        logic       exp_pwr;
        cur_vec_t   exp_cmd;
    } row_t;

    logic       sysclk;
    logic       rst;
    reg_wr_t    reg_wr;
    reg_addr_t  reg_raddr;
    cur_vec_t   cur_fb;
    enc_pins_t  enc;
    board_id_t  board_id;
    reg_data_t  reg_rdata;
    cur_vec_t   cur_cmd;
    axis_mask_t amp_enable;
    logic       pwr_enable;
    axis_mask_t safety_disable;

    row_t                   rows[$];
    int                     max_hold    = 0;
    bit                     table_ready = 1'b0;
    cur_t [`QLA_NUM_AXES:1] fb_now;                     // feedback for the next rows
    cur_t [`QLA_NUM_AXES:1] cmd_now;                    // expected setpoints
    enc_pins_t              pins_now;
    logic                   pwr_now;                    // expected board power

    qla_top dut (
        .sysclk        (sysclk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_raddr     (reg_raddr),
        .cur_fb        (cur_fb),
        .enc           (enc),
        .board_id      (board_id),
        .reg_rdata     (reg_rdata),
        .cur_cmd       (cur_cmd),
        .amp_enable    (amp_enable),
        .pwr_enable    (pwr_enable),
        .safety_disable(safety_disable)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    // ------------------------------------------------------------
    // failure reporting
    task automatic end_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input int idx,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("ERROR %0t: row %0d %s got %0h expected %0h", $time, idx, what, got, exp);
        end_with_failure();
    endtask

    // ------------------------------------------------------------
    // table building
    function automatic reg_addr_t axis_addr(input int chan, input logic [3:0] off);
        return {`ADDR_SPACE_MAIN, 4'h0, chan[3:0], off};
    endfunction

    task automatic add_row(input logic wen, input reg_addr_t waddr, input reg_data_t wdata,
                           input int hold, input reg_addr_t raddr, input reg_data_t exp_rdata,
                           input axis_mask_t exp_amp, input axis_mask_t exp_sdis);
        row_t r;
        if (wen && (waddr == STATUS_ADDR)) begin
            pwr_now = wdata[`STATUS_PWR_BIT];           // power follows each status write
        end
        r = '{wen: wen, waddr: waddr, wdata: wdata, fb: fb_now, pins: pins_now,
              hold: hold, raddr: raddr, exp_rdata: exp_rdata, exp_amp: exp_amp,
              exp_sdis: exp_sdis, exp_pwr: pwr_now, exp_cmd: cmd_now};
        rows.push_back(r);
        if (hold > max_hold) max_hold = hold;
    endtask

    // quadrature phase 0..3 is ab = 00 10 11 01, up the list is forward
    task automatic set_pins(input int n, input int ph);
        pins_now.a[n-1] = (ph == 1) || (ph == 2);
        pins_now.b[n-1] = (ph >= 2);
    endtask

    task automatic build_table();
        enc_count_t pre;
        enc_count_t cnt;
        int         nfwd;
        int         nrev;
        int         ph;
        // reset values, commands at mid, counters clear
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            add_row(0, '0, '0, 1, axis_addr(n, `OFF_DAC_CTRL), 32'h0000_8000, 4'h0, 4'h0);
            add_row(0, '0, '0, 1, axis_addr(n, `OFF_ENC_DATA), 32'h0, 4'h0, 4'h0);
            add_row(0, '0, '0, 1, axis_addr(n, `OFF_ENC_LOAD), 32'h0, 4'h0, 4'h0);
        end
        add_row(0, '0, '0, 1, STATUS_ADDR, 32'h0A00_0000, 4'h0, 4'h0);   // only board id
        add_row(0, '0, '0, 1, 16'h1010, 32'h0, 4'h0, 4'h0);              // other space
        add_row(0, '0, '0, 1, 16'h0051, 32'h0, 4'h0, 4'h0);              // channel 5
        add_row(0, '0, '0, 1, 16'h0012, 32'h0, 4'h0, 4'h0);              // unlisted offset
        add_row(0, '0, '0, 1, 16'h0003, 32'h0, 4'h0, 4'h0);

        // dac writes, upper half of wdata dropped
        cmd_now[2] = 16'h9000;
        add_row(1, axis_addr(2, `OFF_DAC_CTRL), 32'hABCD_9000, 1,
                axis_addr(2, `OFF_DAC_CTRL), 32'h0000_9000, 4'h0, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(1, `OFF_DAC_CTRL), 32'h0000_8000, 4'h0, 4'h0);
        cmd_now[4] = 16'h7000;
        add_row(1, axis_addr(4, `OFF_DAC_CTRL), 32'h0000_7000, 1,
                axis_addr(4, `OFF_DAC_CTRL), 32'h0000_7000, 4'h0, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(3, `OFF_DAC_CTRL), 32'h0000_8000, 4'h0, 4'h0);

        // adc readback, all inside the safety limit
        fb_now[1] = 16'h7F80;
        fb_now[2] = 16'hA000;                           // limit is 0x2100 here
        fb_now[3] = 16'h80F0;
        add_row(0, '0, '0, 1, axis_addr(1, `OFF_ADC_DATA), 32'h0000_7F80, 4'h0, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(2, `OFF_ADC_DATA), 32'h0000_A000, 4'h0, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(3, `OFF_ADC_DATA), 32'h0000_80F0, 4'h0, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(4, `OFF_ADC_DATA), 32'h0000_8000, 4'h0, 4'h0);

        // encoders: preload, forward, reverse, then a double move
        for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
            pre  = enc_count_t'($urandom);
            cnt  = pre;
            nfwd = $urandom_range(6, 1);
            nrev = $urandom_range(6, 1);
            ph   = 0;
            add_row(1, axis_addr(n, `OFF_ENC_LOAD), reg_data_t'(pre), 1,
                    axis_addr(n, `OFF_ENC_DATA), reg_data_t'(pre), 4'h0, 4'h0);
            for (int k = 0; k < nfwd + nrev; k++) begin
                ph  = (k < nfwd) ? (ph + 1) % 4 : (ph + 3) % 4;
                cnt = (k < nfwd) ? cnt + 1'b1 : cnt - 1'b1;   // 24-bit wrap
                set_pins(n, ph);
                add_row(0, '0, '0, 4, axis_addr(n, `OFF_ENC_DATA), reg_data_t'(cnt),
                        4'h0, 4'h0);
            end
            ph = (ph + 2) % 4;                          // both lines at once
            set_pins(n, ph);
            add_row(0, '0, '0, 4, axis_addr(n, `OFF_ENC_DATA), reg_data_t'(cnt), 4'h0, 4'h0);
            add_row(0, '0, '0, 1, axis_addr(n, `OFF_ENC_LOAD), reg_data_t'(pre), 4'h0, 4'h0);
        end

        // status register, power bit is 19
        add_row(1, STATUS_ADDR, 32'h0008_000B, 1, STATUS_ADDR, 32'h0A08_00BB, 4'hB, 4'h0);
        add_row(1, STATUS_ADDR, 32'h0000_0006, 1, STATUS_ADDR, 32'h0A00_0060, 4'h0, 4'h0);
        add_row(1, STATUS_ADDR, 32'h0008_000F, 1, STATUS_ADDR, 32'h0A08_00FF, 4'hF, 4'h0);

        // ------------------------------------------------------------
        // safety: exactly at the limit, then one over on axis 3
        fb_now[3] = 16'h8100;                           // dev 0x100, limit 0x100
        fb_now[4] = 16'h5F00;                           // dev 0x2100, limit 0x2100
        add_row(0, '0, '0, `SAFETY_CYCLES + 4, STATUS_ADDR, 32'h0A08_00FF, 4'hF, 4'h0);
        fb_now[3] = 16'h7EFF;                           // dev 0x101
        add_row(0, '0, '0, `SAFETY_CYCLES + 2, STATUS_ADDR, 32'h0A08_04FB, 4'hB, 4'h4);
        fb_now[3] = 16'h8000;                           // back in range, still latched
        add_row(0, '0, '0, 3, STATUS_ADDR, 32'h0A08_04FB, 4'hB, 4'h4);
        add_row(1, STATUS_ADDR, 32'h0008_000F, 2, STATUS_ADDR, 32'h0A08_00FF, 4'hF, 4'h0);
        add_row(0, '0, '0, 1, axis_addr(4, `OFF_ADC_DATA), 32'h0000_5F00, 4'hF, 4'h0);
    endtask

    // ------------------------------------------------------------
    // apply one row, write only in its first cycle
    task automatic apply_row(input int idx);
        row_t r;
        r = rows[idx];
        @(posedge sysclk);
        #DRIVE_DLY;
        reg_wr.wen   = r.wen;
        reg_wr.waddr = r.waddr;
        reg_wr.wdata = r.wdata;
        reg_raddr    = r.raddr;
        cur_fb       = r.fb;
        enc          = r.pins;
        repeat (r.hold) begin
            @(posedge sysclk);
            #DRIVE_DLY;
            reg_wr.wen = 1'b0;
        end
        @(negedge sysclk);                              // settled, next edge far off
        assert (reg_rdata == r.exp_rdata)
            else report_mismatch("reg_rdata", idx, reg_rdata, r.exp_rdata);
        assert (amp_enable == r.exp_amp)
            else report_mismatch("amp_enable", idx, amp_enable, r.exp_amp);
        assert (safety_disable == r.exp_sdis)
            else report_mismatch("safety_disable", idx, safety_disable, r.exp_sdis);
        assert (pwr_enable == r.exp_pwr)
            else report_mismatch("pwr_enable", idx, pwr_enable, r.exp_pwr);
        assert (cur_cmd == r.exp_cmd)
            else report_mismatch("cur_cmd", idx, cur_cmd, r.exp_cmd);
    endtask

    initial begin
        void'($urandom(9));                             // fixed seed
        sysclk    = 1'b0;
        rst       = 1'b1;
        reg_wr    = '0;
        reg_raddr = '0;
        cur_fb    = {`QLA_NUM_AXES{`CUR_MID}};          // zero current, no trips
        enc       = '0;
        board_id  = BOARD_ID;
        fb_now    = {`QLA_NUM_AXES{`CUR_MID}};
        cmd_now   = {`QLA_NUM_AXES{`CUR_MID}};
        pins_now  = '0;
        pwr_now   = 1'b0;                               // power off out of reset
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge sysclk);
        #DRIVE_DLY;
        rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(i);
        end
        $display("all tests passed");
        $finish;
    end

    // watchdog, rows times longest row plus reset
    initial begin : watchdog
        longint limit;
        wait (table_ready);
        limit = longint'(rows.size()) * (max_hold + 1) * CLK_PERIOD
              + (RST_CYCLES + 4) * CLK_PERIOD;
        #(limit);
        $display("timeout: the table rows did not finish within %0d time units", limit);
        end_with_failure();
    end

endmodule

/* all.f */
+incdir+.
qla_pkg.sv
dac_cmd_regs.sv
enc_quad.sv
safety_check.sv
board_regs.sv
qla_top.sv
qla_sva.sv
tb_qla.sv

/* Makefile */
# Verilator build and run of the motor-axis core testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_qla
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "simulation ended without passing"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
